/* vlog.f */
i2cPkg.sv
wbCsr.sv
i2cMasterMux.sv
i2cMaster.sv
keyPadTop.sv
i2cKeyPadModel.sv
tbKeyPadTop.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tbKeyPadTop
RTL_TOP   ?= keyPadTop
RTL_SRCS  ?= i2cPkg.sv wbCsr.sv i2cMasterMux.sv i2cMaster.sv keyPadTop.sv
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o $(TB_TOP)
	./$(OBJ_DIR)/$(TB_TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tbKeyPadTop.sv */
/*
 * Testbench for the keypad polling top level
 * Clock, reset, poll table, Wishbone access tasks
 * Compare tasks, cycle timeout and summary
 */
`timescale 1ns/1ps

module tbKeyPadTop
	import i2cPkg::*;
();

	localparam int numTests     = 6;
	localparam int timeoutLimit = numTests * 2 * 20 * 4 * sclQuarter + 200;

	logic    iSysClk;
	logic    reset;
	wbReqT   wbReq;
	wbRspT   wbRsp;
	logic    sclLowM;
	logic    sdaLowM;
	logic    sclLine;
	logic    sdaLine;
	logic    leftSdaLow;
	logic    rightSdaLow;
	i2cByteT leftKey;
	i2cByteT rightKey;
	logic    rightOn;
	int      errCnt;
	int      cycleCnt;

	// Poll table
	string   tName[$];
	i2cByteT tLeft[$];
	i2cByteT tRight[$];
	logic    tRightOn[$];
	logic    tNack[$];

	initial
	begin
		iSysClk = 1'b0;
		forever #2 iSysClk = ~iSysClk;		// 4 ns period
	end

	keyPadTop uut (
		.iSysClk (iSysClk),
		.reset   (reset),
		.wbReq   (wbReq),
		.wbRsp   (wbRsp),
		.sclLow  (sclLowM),
		.sdaLow  (sdaLowM),
		.sdaIn   (sdaLine)
	);

	// Wired-AND bus, only the master drives SCL
	assign sclLine = ~sclLowM;
	assign sdaLine = ~(sdaLowM | leftSdaLow | rightSdaLow);

	i2cKeyPadModel uLeftPad (
		.iSysClk (iSysClk), .reset (reset), .scl (sclLine), .sda (sdaLine),
		.sdaLow (leftSdaLow), .adrs (keyPadAdrsLeft), .keyByte (leftKey), .present (1'b1)
	);

	i2cKeyPadModel uRightPad (
		.iSysClk (iSysClk), .reset (reset), .scl (sclLine), .sda (sdaLine),
		.sdaLow (rightSdaLow), .adrs (keyPadAdrsRight), .keyByte (rightKey), .present (rightOn)
	);

	// ----------------------------------------------------------
	// Tasks
	// ----------------------------------------------------------
	task automatic addTest(input string name, input i2cByteT left, input i2cByteT right,
			input logic present, input logic nackExp);
		tName.push_back(name);
		tLeft.push_back(left);
		tRight.push_back(right);
		tRightOn.push_back(present);
		tNack.push_back(nackExp);
	endtask

	// One classic cycle, ack expected on the next edge
	task automatic busCycle(input logic we, input wbAdrT adr, input wbDataT datW,
			output wbDataT datR);
		@(posedge iSysClk);
		#1;
		if (wbRsp.ack)
		begin
			errCnt++;
			$display("ERROR: Wishbone ack already high before strobe at %0t", $time);
		end
		wbReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, datW: datW};
		@(posedge iSysClk);
		#1;
		if (!wbRsp.ack)
		begin
			errCnt++;
			$display("ERROR: no Wishbone ack one cycle after strobe at %0t", $time);
		end
		datR  = wbRsp.datR;
		wbReq = '0;				// Drop strobe on ack
	endtask

	task automatic writeReg(input wbAdrT adr, input wbDataT dat);
		wbDataT unused;
		busCycle(1'b1, adr, dat, unused);
	endtask

	task automatic readReg(input wbAdrT adr, output wbDataT dat);
		busCycle(1'b0, adr, '0, dat);
	endtask

	task automatic checkWord(input string name, input wbDataT expVal, input wbDataT actVal);
		if (actVal !== expVal)
		begin
			errCnt++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expVal, actVal);
		end
	endtask

	task automatic checkKeys(input string name, input keyPairT expVal, input keyPairT actVal);
		if (actVal !== expVal)
		begin
			errCnt++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expVal, actVal);
		end
	endtask

	// Hang guard
	initial
	begin
		cycleCnt = 0;
		while (cycleCnt < timeoutLimit)
		begin
			@(posedge iSysClk);
			cycleCnt++;
		end
		$display("ERROR: poll never finished within %0d cycles", timeoutLimit);
		$display("Summary: %0d check errors, 1 timeout", errCnt);
		$display("test failed");
		$finish;
	end

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------
	initial
	begin
		logic [31:0] rnd;
		wbDataT      rd;
		keyPairT     expKeys;

		rnd      = $urandom(70);
		errCnt   = 0;
		reset    = 1'b1;
		wbReq    = '0;
		leftKey  = '0;
		rightKey = '0;
		rightOn  = 1'b1;

		addTest("fixedKeys", 8'hA5, 8'h3C, 1'b1, 1'b0);
		addTest("zeroKeys", 8'h00, 8'h00, 1'b1, 1'b0);
		addTest("rightAbsent", 8'h5A, 8'h12, 1'b0, 1'b1);	// Released line reads FF
		addTest("afterClear", 8'hFF, 8'h81, 1'b1, 1'b0);
		rnd = $urandom;
		addTest("randomA", rnd[15:8], rnd[7:0], 1'b1, 1'b0);
		rnd = $urandom;
		addTest("randomB", rnd[15:8], rnd[7:0], 1'b1, 1'b0);

		repeat (2) @(posedge iSysClk);
		#1;
		reset = 1'b0;

		if (sclLowM !== 1'b0 || sdaLowM !== 1'b0)
		begin
			errCnt++;
			$display("ERROR: I2C pins driven low after reset");
		end
		readReg(regCtrl, rd);
		checkWord("reset.ctrl", 32'h0, rd);
		readReg(regStatus, rd);
		checkWord("reset.status", 32'h0, rd);
		readReg(regKeys, rd);
		checkWord("reset.keys", 32'h0, rd);

		for (int i = 0; i < numTests; i++)
		begin
			leftKey  = tLeft[i];
			rightKey = tRight[i];
			rightOn  = tRightOn[i];
			expKeys  = {tLeft[i], tRightOn[i] ? tRight[i] : 8'hFF};

			writeReg(regCtrl, 32'h1);
			readReg(regCtrl, rd);
			checkWord($sformatf("%s.ctrl", tName[i]), 32'h1, rd);
			writeReg(regCtrl, 32'h1);		// Ignored while busy

			do
				readReg(regStatus, rd);
			while (rd[0]);

			readReg(regKeys, rd);
			checkKeys($sformatf("%s.keys", tName[i]), expKeys, rd[15:0]);
			readReg(regStatus, rd);
			checkWord($sformatf("%s.status", tName[i]), {30'd0, tNack[i], 1'b0}, rd);

			if (tNack[i])
			begin
				writeReg(regStatus, 32'h2);		// Clear sticky NACK
				readReg(regStatus, rd);
				checkWord($sformatf("%s.clear", tName[i]), 32'h0, rd);
			end
		end

		$display("Summary: %0d check errors, 0 timeouts", errCnt);
		if (errCnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* i2cKeyPadModel.sv */
/*
 * I2C keypad slave model for simulation
 * Acknowledges its own read address, returns one key byte
 * Absent model stays silent on the bus
 */
`timescale 1ns/1ps

module i2cKeyPadModel
	import i2cPkg::*;
(
	input  logic       iSysClk,
	input  logic       reset,
	input  logic       scl,			// Resolved lines
	input  logic       sda,
	output logic       sdaLow,
	input  logic [6:0] adrs,
	input  i2cByteT    keyByte,
	input  logic       present
);

	logic       sclPrev;
	logic       sdaPrev;
	logic       active;			// Between START and STOP
	logic       dataPhase;		// 0 address byte, 1 key byte
	logic       selected;
	logic       adrsHit;
	logic [3:0] bitCnt;			// SCL rising edges in this byte
	i2cByteT    rxSh;
	i2cByteT    txSh;

	assign adrsHit = present && (rxSh == {adrs, 1'b1});	// Read bit set

	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			sclPrev   <= 1'b1;
			sdaPrev   <= 1'b1;
			active    <= 1'b0;
			dataPhase <= 1'b0;
			selected  <= 1'b0;
			bitCnt    <= '0;
			sdaLow    <= 1'b0;
		end
		else
		begin
			sclPrev <= scl;
			sdaPrev <= sda;
			if (sclPrev && scl && sdaPrev && !sda)		// START
			begin
				active    <= 1'b1;
				dataPhase <= 1'b0;
				selected  <= 1'b0;
				bitCnt    <= '0;
				sdaLow    <= 1'b0;
			end
			else if (sclPrev && scl && !sdaPrev && sda)	// STOP
			begin
				active <= 1'b0;
				sdaLow <= 1'b0;
			end
			else if (active && !sclPrev && scl)		// SCL rising
			begin
				bitCnt <= bitCnt + 4'd1;
				if (!dataPhase && bitCnt < 4'd8)
					rxSh <= {rxSh[6:0], sda};	// Address MSB first
			end
			else if (active && sclPrev && !scl)		// SCL falling
			begin
				if (!dataPhase)
				begin
					if (bitCnt == 4'd8)
					begin
						selected <= adrsHit;
						sdaLow   <= adrsHit;		// ACK own address
					end
					else if (bitCnt == 4'd9)
					begin
						dataPhase <= 1'b1;
						bitCnt    <= '0;
						txSh      <= keyByte;
						sdaLow    <= selected & ~keyByte[7];
					end
				end
				else if (bitCnt == 4'd8)
					sdaLow <= 1'b0;			// Master ACK/NACK slot
				else if (bitCnt != 4'd0 && bitCnt < 4'd8)
				begin
					sdaLow <= selected & ~txSh[6];
					txSh   <= {txSh[6:0], 1'b0};
				end
			end
		end
	end

endmodule

/* keyPadTop.sv */
/*
 * Keypad polling top level
 * Register block, poll sequencer and I2C master
 */
`timescale 1ns/1ps

module keyPadTop
	import i2cPkg::*;
(
	input  logic  iSysClk,
	input  logic  reset,
	input  wbReqT wbReq,
	output wbRspT wbRsp,
	output logic  sclLow,
	output logic  sdaLow,
	input  logic  sdaIn
);

	logic    pollEn;
	logic    pollDone;
	logic    nackEvt;
	keyPairT keys;
	i2cCmdT  cmd;
	i2cRspT  rsp;

	// Host side
	wbCsr uCsr (
		.iSysClk  (iSysClk),
		.reset    (reset),
		.wbReq    (wbReq),
		.wbRsp    (wbRsp),
		.pollEn   (pollEn),
		.pollDone (pollDone),
		.nackEvt  (nackEvt),
		.keys     (keys)
	);

	// Left then right keypad
	i2cMasterMux uMux (
		.iSysClk  (iSysClk),
		.reset    (reset),
		.pollEn   (pollEn),
		.pollDone (pollDone),
		.cmd      (cmd),
		.rsp      (rsp),
		.keys     (keys),
		.nackEvt  (nackEvt)
	);

	// Open-drain pin side
	i2cMaster uMaster (
		.iSysClk (iSysClk),
		.reset   (reset),
		.cmd     (cmd),
		.rsp     (rsp),
		.sclLow  (sclLow),
		.sdaLow  (sdaLow),
		.sdaIn   (sdaIn)
	);

endmodule

/* i2cMaster.sv */
/*
 * Bit-level I2C master
 * Quarter-period SCL divider, START/STOP, MSB-first byte shift
 * ACK sampling, NACK on the last received byte, open-drain pins
 */
`timescale 1ns/1ps

module i2cMaster
	import i2cPkg::*;
(
	input  logic   iSysClk,
	input  logic   reset,
	input  i2cCmdT cmd,
	output i2cRspT rsp,
	output logic   sclLow,		// Drive SCL low
	output logic   sdaLow,		// Drive SDA low
	input  logic   sdaIn
);

	typedef enum logic [2:0] {msIdle, msStart, msBit, msAck, msStop, msGap} bitStateT;

	bitStateT               bitState;
	logic [quarterCntW-1:0] qCnt;
	logic                   qTick;
	logic [1:0]             phase;		// Quarter within a bit
	logic [2:0]             bitCnt;
	i2cByteT                byteCnt;
	logic                   rxMode;		// Direction of current byte
	logic                   lastByte;
	logic                   sclNext;
	logic                   sdaNext;
	logic                   sampBit;
	i2cByteT                shReg;
	i2cByteT                rxByteR;
	logic                   byteVdR;
	logic                   bufVdR;
	logic                   nackR;

	assign qTick    = (qCnt == quarterCntW'(sclQuarter - 1));
	assign lastByte = (byteCnt == cmd.bufLen - 8'd1);
	assign rsp      = '{bufVd: bufVdR, byteVd: byteVdR, rxByte: rxByteR, nack: nackR};

	// ----------------------------------------------------------
	// Pin decode, quarters 0 and 3 hold SCL low
	// ----------------------------------------------------------
	always_comb
	begin
		sclNext = 1'b0;
		sdaNext = 1'b0;
		case (bitState)
			msStart:
			begin
				sclNext = (phase == 2'd3);
				sdaNext = (phase != 2'd0);	// SDA falls with SCL high
			end
			msBit:
			begin
				sclNext = (phase == 2'd0) || (phase == 2'd3);
				sdaNext = ~rxMode & ~shReg[7];	// Released when receiving
			end
			msAck:
			begin
				sclNext = (phase == 2'd0) || (phase == 2'd3);
				sdaNext = rxMode & ~lastByte;	// NACK the last byte
			end
			msStop:
			begin
				sclNext = (phase == 2'd0);
				sdaNext = (phase != 2'd3);	// SDA rises with SCL high
			end
			default: ;				// Bus released
		endcase
	end

	// ----------------------------------------------------------
	// Bit sequencer
	// ----------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			bitState <= msIdle;
			qCnt     <= '0;
			phase    <= '0;
			bitCnt   <= '0;
			byteCnt  <= '0;
			rxMode   <= 1'b0;
			sclLow   <= 1'b0;
			sdaLow   <= 1'b0;
			byteVdR  <= 1'b0;
			bufVdR   <= 1'b0;
			nackR    <= 1'b0;
		end
		else
		begin
			sclLow  <= sclNext;
			sdaLow  <= sdaNext;
			byteVdR <= 1'b0;
			bufVdR  <= 1'b0;
			nackR   <= 1'b0;
			qCnt    <= (bitState == msIdle || qTick) ? '0 : qCnt + 1'b1;

			if (bitState == msIdle)
			begin
				phase <= '0;
				if (cmd.en)
				begin
					bitState <= msStart;
					byteCnt  <= '0;
				end
			end
			else if (qTick)
			begin
				phase <= phase + 2'd1;
				case (bitState)
					msStart:
					begin
						if (phase == 2'd3)
						begin
							bitState <= msBit;
							bitCnt   <= '0;
							rxMode   <= cmd.triState;
						end
					end
					msBit:
					begin
						if (phase == 2'd3)
						begin
							bitCnt <= bitCnt + 3'd1;	// Wraps to 0 after eight
							if (bitCnt == 3'd7)
								bitState <= msAck;
						end
					end
					msAck:
					begin
						case (phase)
							2'd1: nackR <= ~rxMode & sdaIn;	// Address not acked
							2'd2: byteVdR <= 1'b1;
							2'd3:
							begin
								if (lastByte)
									bitState <= msStop;
								else
								begin
									bitState <= msBit;
									byteCnt  <= byteCnt + 8'd1;
									rxMode   <= cmd.triState;	// Toggled after byteVd
								end
							end
							default: ;
						endcase
					end
					msStop:
					begin
						if (phase == 2'd3)
						begin
							bitState <= msGap;
							bufVdR   <= 1'b1;
						end
					end
					default: bitState <= msIdle;	// One bus-free quarter
				endcase
			end
		end
	end

	// Shift register and sampled data
	always_ff @(posedge iSysClk)
	begin
		if (bitState == msIdle && cmd.en)
			shReg <= cmd.sendByte;
		else if (qTick && bitState == msAck && phase == 2'd3)
			shReg <= cmd.sendByte;
		else if (qTick && bitState == msBit && phase == 2'd3)
			shReg <= {shReg[6:0], sampBit};	// MSB out, new bit in

		if (qTick && bitState == msBit && phase == 2'd1)
			sampBit <= sdaIn;			// SCL high midpoint

		if (qTick && bitState == msAck && phase == 2'd2 && rxMode)
			rxByteR <= shReg;
	end

endmodule

/* i2cMasterMux.sv */
/*
 * Keypad poll sequencer
 * Steps left then right keypad, feeds the I2C master its command
 * Gathers received bytes into the key word
 */
`timescale 1ns/1ps

module i2cMasterMux
	import i2cPkg::*;
(
	input  logic    iSysClk,
	input  logic    reset,
	input  logic    pollEn,
	output logic    pollDone,
	output i2cCmdT  cmd,
	input  i2cRspT  rsp,
	output keyPairT keys,
	output logic    nackEvt
);

	devSelT  devSel;
	logic    enR;
	logic    triR;
	logic    doneR;
	i2cByteT sendR;
	keyPairT keyR;

	// Fixed two-byte transfer
	assign cmd      = '{en: enR, triState: triR, sendByte: sendR, bufLen: i2cBufLen};
	assign pollDone = doneR;
	assign keys     = keyR;
	assign nackEvt  = rsp.nack;		// Straight to sticky flag

	// ----------------------------------------------------------
	// Device select
	// ----------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			devSel <= devStop;
			enR    <= 1'b0;
			triR   <= 1'b0;
			doneR  <= 1'b0;
			keyR   <= '0;
		end
		else
		begin
			case (devSel)
				devStop:     if (pollEn) devSel <= devKeyLeft;
				devKeyLeft:  if (rsp.bufVd) devSel <= devKeyRight;
				devKeyRight: if (rsp.bufVd) devSel <= devComp;
				devComp:     if (!pollEn) devSel <= devStop;	// Wait for CSR release
				default:     devSel <= devStop;
			endcase

			// Master enable lags the state by one cycle
			enR   <= (devSel == devKeyLeft) || (devSel == devKeyRight);
			doneR <= (devSel == devKeyRight) && rsp.bufVd;	// Entering devComp

			// First byte sends, second receives
			if (!enR)
				triR <= 1'b0;
			else if (rsp.byteVd)
				triR <= ~triR;

			if (rsp.bufVd)
				keyR <= {keyR[7:0], rsp.rxByte};	// Left ends up high
		end
	end

	// Address byte with read bit set
	always_ff @(posedge iSysClk)
	begin
		case (devSel)
			devKeyLeft:  sendR <= {keyPadAdrsLeft, 1'b1};
			devKeyRight: sendR <= {keyPadAdrsRight, 1'b1};
			default:     sendR <= sendR;
		endcase
	end

endmodule

/* wbCsr.sv */
/*
 * Wishbone classic register block
 * Control, status and key registers, single-cycle ack
 * Poll enable and sticky NACK flag
 */
`timescale 1ns/1ps

module wbCsr
	import i2cPkg::*;
(
	input  logic    iSysClk,
	input  logic    reset,
	input  wbReqT   wbReq,
	output wbRspT   wbRsp,
	output logic    pollEn,		// Doubles as busy
	input  logic    pollDone,
	input  logic    nackEvt,
	input  keyPairT keys
);

	logic   ackR;
	wbDataT datR;
	logic   nackSticky;
	logic   access;			// New strobe, ack not yet given
	logic   wrEn;

	assign access = wbReq.cyc & wbReq.stb & ~ackR;
	assign wrEn   = access & wbReq.we;
	assign wbRsp  = '{ack: ackR, datR: datR};

	// ----------------------------------------------------------
	// Handshake and control state
	// ----------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			ackR       <= 1'b0;
			pollEn     <= 1'b0;
			nackSticky <= 1'b0;
		end
		else
		begin
			ackR <= access;			// High for exactly one cycle

			// Start ignored while a poll runs
			if (pollDone)
				pollEn <= 1'b0;
			else if (wrEn && wbReq.adr == regCtrl && wbReq.datW[0])
				pollEn <= 1'b1;

			if (nackEvt)
				nackSticky <= 1'b1;	// Set wins over clear
			else if (wrEn && wbReq.adr == regStatus && wbReq.datW[1])
				nackSticky <= 1'b0;	// Write one to clear
		end
	end

	// Read data, valid with ack
	always_ff @(posedge iSysClk)
	begin
		if (access)
		begin
			case (wbReq.adr)
				regCtrl:   datR <= {31'd0, pollEn};
				regStatus: datR <= {30'd0, nackSticky, pollEn};
				regKeys:   datR <= {16'd0, keys};
				default:   datR <= '0;
			endcase
		end
	end

endmodule

/* i2cPkg.sv */
/*
 * Shared types and constants for the keypad polling subsystem
 * Widths, keypad addresses, SCL divider, register map
 * Wishbone and I2C command/response structs, sequencer states
 */
package i2cPkg;

	// ----------------------------------------------------------
	// Widths with a meaning
	// ----------------------------------------------------------
	typedef logic [31:0] wbDataT;	// Wishbone data word
	typedef logic [1:0]  wbAdrT;	// Wishbone word address
	typedef logic [7:0]  i2cByteT;	// One byte on the I2C bus
	typedef logic [15:0] keyPairT;	// Left byte high, right byte low

	// ----------------------------------------------------------
	// Constants
	// ----------------------------------------------------------
	localparam logic [6:0] keyPadAdrsLeft  = 7'h02;
	localparam logic [6:0] keyPadAdrsRight = 7'h03;
	localparam i2cByteT    i2cBufLen       = 8'd2;	// Address + one data byte
	localparam int         sclQuarter      = 4;	// Sys clocks per quarter SCL
	localparam int         quarterCntW     = $clog2(sclQuarter);

	// Register map, word index
	localparam wbAdrT regCtrl   = 2'd0;	// bit0 start/enable
	localparam wbAdrT regStatus = 2'd1;	// bit0 busy, bit1 nack sticky
	localparam wbAdrT regKeys   = 2'd2;	// keyPairT in low half

	// ----------------------------------------------------------
	// Bundles
	// ----------------------------------------------------------
	typedef struct packed {
		logic   cyc;
		logic   stb;
		logic   we;
		wbAdrT  adr;
		wbDataT datW;
	} wbReqT;

	typedef struct packed {
		logic   ack;
		wbDataT datR;
	} wbRspT;

	typedef struct packed {
		logic    en;		// Run transactions while high
		logic    triState;	// 0 send, 1 receive
		i2cByteT sendByte;	// Address byte with read bit
		i2cByteT bufLen;	// Bytes per transaction
	} i2cCmdT;

	typedef struct packed {
		logic    bufVd;		// Pulse after STOP
		logic    byteVd;	// Pulse after ninth SCL
		i2cByteT rxByte;	// Last received byte
		logic    nack;		// Pulse on address NACK
	} i2cRspT;

	typedef enum logic [1:0] {devStop, devKeyLeft, devKeyRight, devComp} devSelT;

endpackage
